//--- design/isa_pkg.sv
package isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// core widths
	// ~~~~~~~~~~~~~~~~~~~~
	localparam int data_width     = 32;
	localparam int pc_width       = 10; // byte address.
	localparam int reg_addr_width = 5;
	localparam int reg_count      = 32;

	// ~~~~~~~~~~~~~~~~~~~~
	// field positions
	// ~~~~~~~~~~~~~~~~~~~~
	localparam int rt_msb    = 24;
	localparam int rt_lsb    = 20;
	localparam int ra_msb    = 19;
	localparam int ra_lsb    = 15;
	localparam int rb_msb    = 14;
	localparam int rb_lsb    = 10;
	localparam int sv_msb    = 9;
	localparam int sv_lsb    = 8;
	localparam int func_msb  = 4;
	localparam int func_lsb  = 0;
	localparam int imm5_msb  = 14;
	localparam int imm5_lsb  = 10;
	localparam int imm14_msb = 13;
	localparam int imm14_lsb = 0;
	localparam int imm15_msb = 14;
	localparam int imm15_lsb = 0;
	localparam int imm20_msb = 19;
	localparam int imm20_lsb = 0;
	localparam int imm24_msb = 23;
	localparam int imm24_lsb = 0;

	// unlisted codes run as no-ops.
	typedef enum logic [5:0] {
		op_lwi  = 6'b000010,
		op_swi  = 6'b001010,
		op_lwr  = 6'b011100,
		op_alu  = 6'b100000,
		op_movi = 6'b100010,
		op_j    = 6'b100100,
		op_beq  = 6'b100110,
		op_bne  = 6'b100111,
		op_addi = 6'b101000,
		op_ori  = 6'b101100
	} opcode_t;

	typedef enum logic [4:0] {
		fn_add  = 5'b00000,
		fn_sub  = 5'b00001,
		fn_and  = 5'b00010,
		fn_xor  = 5'b00011,
		fn_or   = 5'b00100,
		fn_slli = 5'b01000
	} alu_func_t;

	typedef struct packed {
		logic        rsv;
		opcode_t     opcode; // bits 30..25.
		logic [24:0] body;
	} instr_t;

endpackage

//--- design/datapath_pkg.sv
package datapath_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// select codes
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		pc_seq  = 2'b00,
		pc_br14 = 2'b01,
		pc_j24  = 2'b10
	} pc_sel_t;

	typedef enum logic [1:0] {
		imm_ze5  = 2'b00,
		imm_se15 = 2'b01,
		imm_ze15 = 2'b10,
		imm_se20 = 2'b11
	} imm_sel_t;

	typedef enum logic [2:0] {
		src2_rb       = 3'b000,
		src2_imm      = 3'b001,
		src2_word_off = 3'b010, // se15 times four.
		src2_rb_sv    = 3'b011,
		src2_rt       = 3'b100
	} src2_sel_t;

	typedef enum logic [1:0] {
		wb_alu = 2'b00,
		wb_imm = 2'b01,
		wb_mem = 2'b10
	} wb_sel_t;

	typedef struct packed {
		pc_sel_t                            pc_sel;
		imm_sel_t                           imm_sel;
		src2_sel_t                          src2_sel;
		wb_sel_t                            wb_sel;
		isa_pkg::alu_func_t                 alu_func;
		logic                               reg_write;
		logic                               mem_write;
		logic                               is_beq;
		logic                               is_bne;
		logic [isa_pkg::reg_addr_width-1:0] rd;
	} ctrl_t;

	// register write port.
	typedef struct packed {
		logic                               en;
		logic [isa_pkg::reg_addr_width-1:0] addr;
		logic [isa_pkg::data_width-1:0]     data;
	} wb_t;

	typedef struct packed {
		logic                           en;
		logic [isa_pkg::data_width-1:0] addr;
		logic [isa_pkg::data_width-1:0] data;
	} store_t;

endpackage

//--- design/instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
	input  isa_pkg::instr_t     instr,
	output datapath_pkg::ctrl_t ctrl
);

	import isa_pkg::*;
	import datapath_pkg::*;

	alu_func_t func;

	assign func = alu_func_t'(instr[func_msb:func_lsb]);

	always_comb begin
		// no-op unless an opcode below says otherwise.
		ctrl           = '0;
		ctrl.pc_sel    = pc_seq;
		ctrl.imm_sel   = imm_se15;
		ctrl.src2_sel  = src2_rb;
		ctrl.wb_sel    = wb_alu;
		ctrl.alu_func  = fn_add;
		ctrl.rd        = instr[rt_msb:rt_lsb];

		case (instr.opcode)
			op_alu: begin
				ctrl.alu_func  = func;
				ctrl.reg_write = 1'b1;
				if (func == fn_slli) begin
					ctrl.imm_sel  = imm_ze5;
					ctrl.src2_sel = src2_imm;
				end
			end
			op_addi: begin
				ctrl.imm_sel   = imm_se15;
				ctrl.src2_sel  = src2_imm;
				ctrl.reg_write = 1'b1;
			end
			op_ori: begin
				ctrl.imm_sel   = imm_ze15;
				ctrl.src2_sel  = src2_imm;
				ctrl.alu_func  = fn_or;
				ctrl.reg_write = 1'b1;
			end
			op_movi: begin
				ctrl.imm_sel   = imm_se20;
				ctrl.src2_sel  = src2_imm;
				ctrl.wb_sel    = wb_imm; // bypasses the alu.
				ctrl.reg_write = 1'b1;
			end
			op_lwi: begin
				ctrl.src2_sel  = src2_word_off;
				ctrl.wb_sel    = wb_mem;
				ctrl.reg_write = 1'b1;
			end
			op_lwr: begin
				ctrl.src2_sel  = src2_rb_sv;
				ctrl.wb_sel    = wb_mem;
				ctrl.reg_write = 1'b1;
			end
			op_swi: begin
				ctrl.src2_sel  = src2_word_off;
				ctrl.mem_write = 1'b1;
			end
			// compare ra with rt through a subtract.
			op_beq: begin
				ctrl.pc_sel   = pc_br14;
				ctrl.src2_sel = src2_rt;
				ctrl.alu_func = fn_sub;
				ctrl.is_beq   = 1'b1;
			end
			op_bne: begin
				ctrl.pc_sel   = pc_br14;
				ctrl.src2_sel = src2_rt;
				ctrl.alu_func = fn_sub;
				ctrl.is_bne   = 1'b1;
			end
			op_j: begin
				ctrl.pc_sel = pc_j24;
			end
			default: begin
				ctrl.pc_sel = pc_seq;
			end
		endcase
	end

endmodule

//--- design/datapath_mux.sv
`timescale 1ns/100ps

module datapath_mux (
	input  datapath_pkg::ctrl_t               ctrl,
	input  datapath_pkg::pc_sel_t             pc_sel,
	input  logic [isa_pkg::pc_width-1:0]      current_pc,
	input  isa_pkg::instr_t                   instr,
	input  logic [isa_pkg::data_width-1:0]    rb_data,
	input  logic [isa_pkg::data_width-1:0]    rt_data,
	input  logic [isa_pkg::data_width-1:0]    alu_result,
	input  logic [isa_pkg::data_width-1:0]    mem_read_data,
	output logic [isa_pkg::pc_width-1:0]      next_pc,
	output logic [isa_pkg::data_width-1:0]    operand2,
	output logic [isa_pkg::data_width-1:0]    wb_data
);

	import isa_pkg::*;
	import datapath_pkg::*;

	logic [data_width-1:0] imm;

	// ~~~~~~~~~~~~~~~~~~~~
	// next pc
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (pc_sel)
			pc_br14: next_pc = current_pc +
				{instr[imm14_msb], instr[imm14_lsb+7:imm14_lsb], 1'b0};
			pc_j24:  next_pc = current_pc +
				{instr[imm24_msb], instr[imm24_lsb+7:imm24_lsb], 1'b0};
			default: next_pc = current_pc + pc_width'(4); // wraps at 10 bits.
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// immediate extension
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (ctrl.imm_sel)
			imm_ze5:  imm = data_width'(instr[imm5_msb:imm5_lsb]);
			imm_se15: imm = {{(data_width-15){instr[imm15_msb]}}, instr[imm15_msb:imm15_lsb]};
			imm_ze15: imm = data_width'(instr[imm15_msb:imm15_lsb]);
			imm_se20: imm = {{(data_width-20){instr[imm20_msb]}}, instr[imm20_msb:imm20_lsb]};
			default:  imm = '0;
		endcase
	end

	// alu operand 2.
	always_comb begin
		case (ctrl.src2_sel)
			src2_rb:       operand2 = rb_data;
			src2_imm:      operand2 = imm;
			src2_word_off: begin
				operand2 = {{(data_width-17){instr[imm15_msb]}},
					instr[imm15_msb:imm15_lsb], 2'b00};
			end
			src2_rb_sv:    operand2 = rb_data << instr[sv_msb:sv_lsb];
			src2_rt:       operand2 = rt_data;
			default:       operand2 = '0;
		endcase
	end

	// write-back source.
	always_comb begin
		case (ctrl.wb_sel)
			wb_alu:  wb_data = alu_result;
			wb_imm:  wb_data = operand2;
			wb_mem:  wb_data = mem_read_data;
			default: wb_data = '0;
		endcase
	end

endmodule

//--- design/alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
	input  isa_pkg::alu_func_t             func,
	input  logic [isa_pkg::data_width-1:0] operand1,
	input  logic [isa_pkg::data_width-1:0] operand2,
	output logic [isa_pkg::data_width-1:0] result,
	output logic                           zero
);

	import isa_pkg::*;

	logic [4:0] shamt;

	assign shamt = operand2[4:0]; // low five bits only.

	always_comb begin
		case (func)
			fn_add: begin
				result = operand1 + operand2;
			end
			fn_sub: begin
				result = operand1 - operand2;
			end
			fn_and: begin
				result = operand1 & operand2;
			end
			fn_or: begin
				result = operand1 | operand2;
			end
			fn_xor: begin
				result = operand1 ^ operand2;
			end
			fn_slli: begin
				result = operand1 << shamt;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// branch compare.
	assign zero = (result == '0);

endmodule

//--- design/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [isa_pkg::reg_addr_width-1:0] ra_addr,
	input  logic [isa_pkg::reg_addr_width-1:0] rb_addr,
	input  logic [isa_pkg::reg_addr_width-1:0] rt_addr,
	input  datapath_pkg::wb_t                  wb,
	output logic [isa_pkg::data_width-1:0]     ra_data,
	output logic [isa_pkg::data_width-1:0]     rb_data,
	output logic [isa_pkg::data_width-1:0]     rt_data
);

	import isa_pkg::*;

	logic [data_width-1:0] regs [reg_count];

	// r0 is an ordinary register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// asynchronous reads.
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

//--- design/cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
	input  logic                           clk,
	input  logic                           rst_n,
	input  isa_pkg::instr_t                instr,
	input  logic [isa_pkg::data_width-1:0] mem_read_data,
	output logic [isa_pkg::pc_width-1:0]   pc,
	output logic [isa_pkg::data_width-1:0] mem_addr,
	output datapath_pkg::store_t           store,
	output datapath_pkg::wb_t              wb
);

	import isa_pkg::*;
	import datapath_pkg::*;

	ctrl_t                 ctrl;
	pc_sel_t               pc_sel;
	logic [pc_width-1:0]   next_pc;
	logic [data_width-1:0] ra_data;
	logic [data_width-1:0] rb_data;
	logic [data_width-1:0] rt_data;
	logic [data_width-1:0] operand2;
	logic [data_width-1:0] alu_result;
	logic [data_width-1:0] wb_data;
	logic                  zero;

	// ~~~~~~~~~~~~~~~~~~~~
	// pc and branch resolve
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		pc_sel = ctrl.pc_sel;
		if ((ctrl.is_beq && !zero) || (ctrl.is_bne && zero)) begin
			pc_sel = pc_seq; // not taken.
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

	instr_decode decode_i (
		.instr (instr),
		.ctrl  (ctrl)
	);

	reg_file reg_file_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (instr[ra_msb:ra_lsb]),
		.rb_addr (instr[rb_msb:rb_lsb]),
		.rt_addr (instr[rt_msb:rt_lsb]),
		.wb      (wb),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rt_data (rt_data)
	);

	datapath_mux mux_i (
		.ctrl          (ctrl),
		.pc_sel        (pc_sel),
		.current_pc    (pc),
		.instr         (instr),
		.rb_data       (rb_data),
		.rt_data       (rt_data),
		.alu_result    (alu_result),
		.mem_read_data (mem_read_data),
		.next_pc       (next_pc),
		.operand2      (operand2),
		.wb_data       (wb_data)
	);

	alu_unit alu_i (
		.func     (ctrl.alu_func),
		.operand1 (ra_data),
		.operand2 (operand2),
		.result   (alu_result),
		.zero     (zero)
	);

	// memory and write-back ports.
	assign mem_addr = alu_result;
	assign store    = '{en: ctrl.mem_write, addr: alu_result, data: rt_data};
	assign wb       = '{en: ctrl.reg_write, addr: ctrl.rd, data: wb_data};

endmodule

//--- verification/cpu_core_checker.sv
`timescale 1ns/100ps

module cpu_core_checker (
	input logic                         clk,
	input logic                         rst_n,
	input logic [isa_pkg::pc_width-1:0] pc,
	input isa_pkg::instr_t              instr,
	input datapath_pkg::ctrl_t          ctrl,
	input datapath_pkg::wb_t            wb,
	input datapath_pkg::store_t         store
);

	import isa_pkg::*;
	import datapath_pkg::*;

	int unsigned fail_count = 0;

	// one port per instruction.
	wb_store_apart: assert property (@(posedge clk) disable iff (!rst_n) !(wb.en && store.en))
		else begin fail_count++; $error("wb and store enabled in the same cycle."); end

	pc_bit0_clear: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0)
		else begin fail_count++; $error("pc bit 0 set."); end

	// ~~~~~~~~~~~~~~~~~~~~
	// low pc bits
	// ~~~~~~~~~~~~~~~~~~~~
	seq_keeps_low: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.pc_sel == pc_seq |=> pc[1:0] == $past(pc[1:0]))
		else begin fail_count++; $error("sequential step changed pc low bits."); end

	jump_low: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.pc_sel == pc_j24 |=> pc[1] == ($past(pc[1]) ^ $past(instr[0]))) // offset bit 1.
		else begin fail_count++; $error("jump left wrong pc bit 1."); end

	wb_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !wb.en)
		else begin fail_count++; $error("wb enabled during reset."); end

endmodule

//--- verification/cpu_core_tb.sv
`timescale 1ns/100ps

module cpu_core_tb;

	import isa_pkg::*;
	import datapath_pkg::*;

	localparam int clk_period   = 8;
	localparam int reset_cycles = 10;
	localparam int run_len      = 200;
	localparam int total_cycles = 7 * (run_len + reset_cycles);
	localparam logic [31:0] nop_word = {1'b0, 6'b111111, 25'd0};

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  hold_nop;
	instr_t                instr;
	logic [data_width-1:0] mem_read_data;
	logic [data_width-1:0] mem_addr;
	logic [pc_width-1:0]   pc;
	store_t                store;
	wb_t                   wb;

	logic [31:0]         rom [256];
	logic [31:0]         dmem [256];
	logic [31:0]         model_mem [256];
	logic [31:0]         model_regs [32];
	logic [pc_width-1:0] model_pc;
	int                  seed;
	int                  checks = 0;
	int                  errors = 0;
	int                  test_errors;

	cpu_core dut_i (.clk, .rst_n, .instr, .mem_read_data, .pc, .mem_addr, .store, .wb);

	bind cpu_core cpu_core_checker checker_i (.clk, .rst_n, .pc, .instr, .ctrl, .wb, .store);

	initial forever #(clk_period / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~
	// memory models
	// ~~~~~~~~~~~~~~~~~~~~
	assign instr         = hold_nop ? instr_t'(nop_word) : instr_t'(rom[pc[9:2]]);
	assign mem_read_data = dmem[mem_addr[9:2]];

	always @(posedge clk) begin
		if (store.en) dmem[store.addr[9:2]] <= store.data;
	end

	task automatic compare_wb(wb_t exp);
		checks++;
		if (wb.en !== exp.en || (exp.en && (wb.addr !== exp.addr || wb.data !== exp.data))) begin
			test_errors++;
			$display("ERR %0t: wb got en=%0b r%0d=%08h, expected en=%0b r%0d=%08h", $time,
				wb.en, wb.addr, wb.data, exp.en, exp.addr, exp.data);
		end
	endtask

	task automatic compare_store(store_t exp);
		checks++;
		if (store.en !== exp.en ||
			(exp.en && (store.addr !== exp.addr || store.data !== exp.data))) begin
			test_errors++;
			$display("ERR %0t: store got en=%0b [%08h]=%08h, expected en=%0b [%08h]=%08h", $time,
				store.en, store.addr, store.data, exp.en, exp.addr, exp.data);
		end
	endtask

	task automatic compare_pc(logic [pc_width-1:0] exp);
		checks++;
		if (pc !== exp) begin
			test_errors++;
			$display("ERR %0t: pc got %03h, expected %03h", $time, pc, exp);
		end
	endtask

	task automatic compare_mem_addr(logic [data_width-1:0] exp);
		checks++;
		if (mem_addr !== exp) begin
			test_errors++;
			$display("ERR %0t: mem_addr got %08h, expected %08h", $time, mem_addr, exp);
		end
	endtask

	function automatic logic [31:0] random_instr(int kind);
		opcode_t     ops [6];
		alu_func_t   funcs [6];
		logic [31:0] w;
		funcs = '{fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_slli};
		case (kind)
			0: ops = '{op_alu, op_alu, op_alu, op_alu, op_movi, op_movi};
			1: ops = '{op_addi, op_ori, op_movi, op_addi, op_ori, op_movi};
			2: ops = '{op_lwi, op_lwr, op_movi, op_addi, op_lwi, op_lwr};
			3: ops = '{op_swi, op_swi, op_lwi, op_lwr, op_movi, op_addi};
			4: ops = '{op_beq, op_bne, op_j, op_movi, op_addi, op_alu};
			default: ops = '{op_alu, op_lwi, op_swi, op_beq, op_movi, op_j};
		endcase
		w        = $random(seed);
		w[31]    = 1'b0;
		w[30:25] = ops[{$random(seed)} % 6];
		if (w[30:25] == op_alu) w[4:0] = funcs[{$random(seed)} % 6];
		// few registers keep results feeding each other.
		if (w[30:25] != op_j) w[24:23] = 2'b00;
		if (w[30:25] != op_j && w[30:25] != op_movi) w[19:18] = 2'b00;
		if (w[30:25] == op_lwr || (w[30:25] == op_alu && w[4:0] != fn_slli)) w[14:13] = 2'b00;
		return w;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic execute_and_check();
		logic [31:0]         w;
		logic [31:0]         a;
		logic [31:0]         b;
		logic [31:0]         t;
		logic [31:0]         se15;
		logic [31:0]         addr;
		logic [pc_width-1:0] next;
		wb_t                 exp_wb;
		store_t              exp_st;
		w      = rom[model_pc[9:2]];
		a      = model_regs[w[19:15]];
		b      = model_regs[w[14:10]];
		t      = model_regs[w[24:20]];
		se15   = {{17{w[14]}}, w[14:0]};
		next   = model_pc + 10'd4;
		exp_wb = '{en: 1'b1, addr: w[24:20], data: '0};
		exp_st = '0;
		case (w[30:25])
			op_alu: begin
				case (w[4:0])
					fn_add:  exp_wb.data = a + b;
					fn_sub:  exp_wb.data = a - b;
					fn_and:  exp_wb.data = a & b;
					fn_or:   exp_wb.data = a | b;
					fn_xor:  exp_wb.data = a ^ b;
					default: exp_wb.data = a << w[14:10];
				endcase
			end
			op_addi: exp_wb.data = a + se15;
			op_ori:  exp_wb.data = a | {17'd0, w[14:0]};
			op_movi: exp_wb.data = {{12{w[19]}}, w[19:0]};
			op_lwi: begin
				addr        = a + (se15 << 2);
				exp_wb.data = model_mem[addr[9:2]];
			end
			op_lwr: begin
				addr        = a + (b << w[9:8]); // index scaled by sv.
				exp_wb.data = model_mem[addr[9:2]];
			end
			op_swi: begin
				exp_wb.en = 1'b0;
				exp_st    = '{en: 1'b1, addr: a + (se15 << 2), data: t};
			end
			op_beq: begin
				exp_wb.en = 1'b0;
				if (a == t) next = model_pc + {w[13], w[7:0], 1'b0};
			end
			op_bne: begin
				exp_wb.en = 1'b0;
				if (a != t) next = model_pc + {w[13], w[7:0], 1'b0};
			end
			op_j: begin
				exp_wb.en = 1'b0;
				next      = model_pc + {w[23], w[7:0], 1'b0};
			end
			default: exp_wb.en = 1'b0;
		endcase
		compare_pc(model_pc);
		compare_wb(exp_wb);
		compare_store(exp_st);
		if (w[30:25] == op_lwi || w[30:25] == op_lwr) compare_mem_addr(addr);
		if (exp_st.en) model_mem[exp_st.addr[9:2]] = exp_st.data;
		if (exp_wb.en) model_regs[exp_wb.addr] = exp_wb.data;
		model_pc = next;
	endtask

	task automatic apply_reset();
		hold_nop = 1'b1; // no-op keeps wb and store idle.
		rst_n    = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		rst_n    = 1'b1;
		hold_nop = 1'b0;
		model_pc = '0;
		foreach (model_regs[i]) model_regs[i] = '0;
	endtask

	task automatic run_cycles(int n);
		repeat (n) begin
			#(clk_period / 4); // settled after the falling edge.
			execute_and_check();
			@(negedge clk);
		end
	endtask

	task automatic run_test(int kind, string name);
		test_errors = 0;
		foreach (rom[i]) begin
			rom[i]       = random_instr(kind);
			dmem[i]      = $random(seed);
			model_mem[i] = dmem[i];
		end
		apply_reset();
		run_cycles(run_len);
		if (kind == 5) begin
			apply_reset(); // same program and memory.
			run_cycles(run_len);
		end
		errors += test_errors;
		$display("test %0d (%s) done: %0d errors", kind + 1, name, test_errors);
	endtask

	initial begin
		seed     = 32'h0295_372a;
		rst_n    = 1'b0;
		hold_nop = 1'b1;
		run_test(0, "register alu and slli");
		run_test(1, "immediates");
		run_test(2, "loads");
		run_test(3, "stores and reload");
		run_test(4, "branches and jumps");
		run_test(5, "reset in mid-run");
		errors += dut_i.checker_i.fail_count;
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#((total_cycles + 100) * clk_period);
		$display("watchdog: the run did not finish within %0d cycles", total_cycles + 100);
		$display("Test failed");
		$finish;
	end

endmodule

//--- cpu_core.f
design/isa_pkg.sv
design/datapath_pkg.sv
design/instr_decode.sv
design/datapath_mux.sv
design/alu_unit.sv
design/reg_file.sv
design/cpu_core.sv
verification/cpu_core_checker.sv
verification/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - design/isa_pkg.sv
  - design/datapath_pkg.sv
  - design/instr_decode.sv
  - design/datapath_mux.sv
  - design/alu_unit.sv
  - design/reg_file.sv
  - design/cpu_core.sv
  - target: test
    files:
      - verification/cpu_core_checker.sv
      - verification/cpu_core_tb.sv
